//--- logic/fpAdder_consts.svh
// Binary32 field widths, exponent bias and limit, aligned mantissa width, canonical NaN
`ifndef FP_ADDER_CONSTS_SVH
`define FP_ADDER_CONSTS_SVH

// Field widths of the binary32 format
`define FP_EXP_W    8
`define FP_MAN_W    23

`define FP_BIAS     127
`define FP_EXP_MAX  255          // All-ones exponent, infinity or NaN

// Hidden bit, fraction and 8 extension bits for guard/round/sticky
`define FP_ALIGN_W  32

`define FP_QNAN     32'h7FC0_0000 // Quiet NaN with only the top fraction bit set

`endif

//--- logic/fpAdderPkg.sv
// Opcode enum and packed structs shared by the floating-point adder stages
package fpAdderPkg;

    typedef enum logic
    {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } fpOp;

    typedef logic [31:0] fpWord;

    typedef struct packed
    {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fpOperand;

    typedef struct packed
    {
        logic isNaN;
        logic isInf;
        logic isZero;
        logic isSub;
    } fpClass;

    // Output of the input stage, B already sign-flipped for a subtract
    typedef struct packed
    {
        fpOperand operandA;
        fpOperand operandB;
        fpClass   classA;
        fpClass   classB;
    } fpUnpacked;

    typedef struct packed
    {
        logic        signA;
        logic        signB;
        logic [7:0]  exponentOut;
        logic [31:0] alignedMantissaA;
        logic [31:0] alignedMantissaB;
        logic        guardBit;
        logic        roundBit;
        logic        stickyBit;
        logic        bypass;     // Special operand present, arithmetic result unused
    } fpAligned;

    typedef struct packed
    {
        logic invalid;
        logic overflow;
        logic inexact;
    } fpFlags;

    typedef struct packed
    {
        fpWord  result;
        fpFlags flags;
    } fpSpecial;

endpackage

//--- logic/fpUnpack.sv
// Input register, subtract sign flip, field split and operand classification
`timescale 1ns/10ps
`include "fpAdder_consts.svh"

module fpUnpack (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inValid,
    input  fpAdderPkg::fpOp       op,
    input  fpAdderPkg::fpWord     operandA,
    input  fpAdderPkg::fpWord     operandB,
    output logic                  stageValid,
    output fpAdderPkg::fpUnpacked unpacked
);

    fpAdderPkg::fpOperand regA;
    fpAdderPkg::fpOperand regB;

    function automatic fpAdderPkg::fpClass classify(input fpAdderPkg::fpOperand x);
        fpAdderPkg::fpClass c;
        logic expOnes;
        logic expZero;
        logic fracZero;
        expOnes  = (x.exponent == `FP_EXP_W'(`FP_EXP_MAX));
        expZero  = (x.exponent == '0);
        fracZero = (x.mantissa == '0);
        c.isNaN  = expOnes & ~fracZero;
        c.isInf  = expOnes & fracZero;
        c.isZero = expZero & fracZero;
        c.isSub  = expZero & ~fracZero;
        return c;
    endfunction

    always_ff @(posedge clk)
    begin
        if (rst)
            stageValid <= 1'b0;
        else
            stageValid <= inValid;
    end

    // Operands are only captured on a strobe
    always_ff @(posedge clk)
    begin
        if (inValid)
        begin
            regA <= operandA;
            // A subtract becomes an add of the negated B
            regB <= {operandB[31] ^ (op == fpAdderPkg::OP_SUB), operandB[30:0]};
        end
    end

    assign unpacked.operandA = regA;
    assign unpacked.operandB = regB;
    assign unpacked.classA   = classify(regA);
    assign unpacked.classB   = classify(regB);

endmodule

//--- logic/fpAlign.sv
// Exponent compare, mantissa alignment, guard/round/sticky and bypass decision
`timescale 1ns/10ps
`include "fpAdder_consts.svh"

module fpAlign (
    input  fpAdderPkg::fpUnpacked unpacked,
    output fpAdderPkg::fpAligned  aligned
);

    fpAdderPkg::fpOperand     opA;
    fpAdderPkg::fpOperand     opB;
    logic [7:0]               expA;
    logic [7:0]               expB;
    logic [`FP_ALIGN_W-1:0]   fullA;
    logic [`FP_ALIGN_W-1:0]   fullB;
    logic                     aLarger;
    logic [7:0]               expDiff;
    logic [5:0]               shiftAmt;
    logic [`FP_ALIGN_W-1:0]   smallFull;
    logic [2*`FP_ALIGN_W-1:0] shiftWide;   // Upper half kept, lower half shifted out

    assign opA = unpacked.operandA;
    assign opB = unpacked.operandB;

    // Subnormals sit at exponent 1 without the hidden bit
    assign expA = unpacked.classA.isSub ? 8'd1 : opA.exponent;
    assign expB = unpacked.classB.isSub ? 8'd1 : opB.exponent;

    assign fullA = {|opA.exponent, opA.mantissa, {(`FP_ALIGN_W-`FP_MAN_W-1){1'b0}}};
    assign fullB = {|opB.exponent, opB.mantissa, {(`FP_ALIGN_W-`FP_MAN_W-1){1'b0}}};

    assign aLarger   = (expA >= expB);
    assign expDiff   = aLarger ? (expA - expB) : (expB - expA);
    assign smallFull = aLarger ? fullB : fullA;

    // Anything past 32 places leaves nothing in the kept half
    assign shiftAmt  = (expDiff > 8'd32) ? 6'd32 : expDiff[5:0];
    assign shiftWide = {smallFull, {`FP_ALIGN_W{1'b0}}} >> shiftAmt;

    always_comb
    begin
        aligned.signA       = opA.sign;
        aligned.signB       = opB.sign;
        aligned.exponentOut = aLarger ? expA : expB;

        if (aLarger)
        begin
            aligned.alignedMantissaA = fullA;
            aligned.alignedMantissaB = shiftWide[2*`FP_ALIGN_W-1:`FP_ALIGN_W];
        end
        else
        begin
            aligned.alignedMantissaA = shiftWide[2*`FP_ALIGN_W-1:`FP_ALIGN_W];
            aligned.alignedMantissaB = fullB;
        end

        // Two bits under the fraction LSB, then everything below them
        aligned.guardBit  = shiftWide[`FP_ALIGN_W+7];
        aligned.roundBit  = shiftWide[`FP_ALIGN_W+6];
        aligned.stickyBit = |shiftWide[`FP_ALIGN_W+5:0];

        aligned.bypass = unpacked.classA.isNaN | unpacked.classB.isNaN |
                         unpacked.classA.isInf | unpacked.classB.isInf |
                         unpacked.classA.isZero | unpacked.classB.isZero;
    end

endmodule

//--- logic/fpSpecialCase.sv
// Result and flags when an operand is NaN, infinity or zero
`timescale 1ns/10ps
`include "fpAdder_consts.svh"

module fpSpecialCase (
    input  fpAdderPkg::fpUnpacked unpacked,
    output fpAdderPkg::fpSpecial  special
);

    fpAdderPkg::fpOperand opA;
    fpAdderPkg::fpOperand opB;
    fpAdderPkg::fpClass   cA;
    fpAdderPkg::fpClass   cB;

    assign opA = unpacked.operandA;
    assign opB = unpacked.operandB;
    assign cA  = unpacked.classA;
    assign cB  = unpacked.classB;

    // Priority follows IEEE 754, NaN first
    always_comb
    begin
        special.flags = '0;
        if (cA.isNaN | cB.isNaN)
            special.result = `FP_QNAN;
        else if (cA.isInf & cB.isInf & (opA.sign != opB.sign))
        begin
            special.result        = `FP_QNAN;   // inf - inf
            special.flags.invalid = 1'b1;
        end
        else if (cA.isInf)
            special.result = opA;
        else if (cB.isInf)
            special.result = opB;
        else if (cA.isZero & cB.isZero)
            special.result = {opA.sign & opB.sign, {(`FP_EXP_W+`FP_MAN_W){1'b0}}};
        else if (cA.isZero)
            special.result = opB;
        else if (cB.isZero)
            special.result = opA;
        else
            special.result = '0;   // Arithmetic path owns this case
    end

endmodule

//--- logic/fpAddNormRound.sv
// Mantissa add/subtract, normalization, nearest-even rounding and output register
`timescale 1ns/10ps
`include "fpAdder_consts.svh"

module fpAddNormRound (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stageValid,
    input  fpAdderPkg::fpAligned aligned,
    input  fpAdderPkg::fpSpecial special,
    output logic                 outValid,
    output fpAdderPkg::fpWord    result,
    output fpAdderPkg::fpFlags   flags
);

    // Extended significand is hidden bit, fraction, guard, round, sticky
    logic                   aLarger;
    logic [`FP_MAN_W+3:0]   largeExt;
    logic [`FP_MAN_W+3:0]   smallExt;
    logic                   effSub;
    logic                   resultSign;
    logic [`FP_MAN_W+4:0]   rawSum;
    logic [4:0]             lzCount;
    logic [7:0]             shiftLimit;
    logic [4:0]             leftShift;
    logic [`FP_MAN_W+3:0]   norm;
    logic [8:0]             normExp;
    logic [8:0]             expField;
    logic                   roundUp;
    logic [`FP_MAN_W+8:0]   rounded;   // Exponent field with carry room, then fraction
    fpAdderPkg::fpWord      sumWord;
    fpAdderPkg::fpFlags     sumFlags;

    // The shifted operand always has the smaller magnitude
    assign aLarger = (aligned.alignedMantissaA >= aligned.alignedMantissaB);

    always_comb
    begin
        if (aLarger)
        begin
            largeExt   = {aligned.alignedMantissaA[31:8], 3'b000};
            smallExt   = {aligned.alignedMantissaB[31:8], aligned.guardBit,
                          aligned.roundBit, aligned.stickyBit};
            resultSign = aligned.signA;
        end
        else
        begin
            largeExt   = {aligned.alignedMantissaB[31:8], 3'b000};
            smallExt   = {aligned.alignedMantissaA[31:8], aligned.guardBit,
                          aligned.roundBit, aligned.stickyBit};
            resultSign = aligned.signB;
        end

        effSub = aligned.signA ^ aligned.signB;
        if (effSub)
            rawSum = {1'b0, largeExt} - {1'b0, smallExt};
        else
            rawSum = {1'b0, largeExt} + {1'b0, smallExt};

        lzCount = 5'd0;
        for (int i = 0; i < `FP_MAN_W+4; i++)
        begin
            if (rawSum[i])
                lzCount = 5'(`FP_MAN_W + 3 - i);   // Highest set bit wins
        end

        // Stop at exponent 1 so small results go subnormal
        shiftLimit = aligned.exponentOut - 8'd1;
        leftShift  = ({3'b000, lzCount} > shiftLimit) ? shiftLimit[4:0] : lzCount;

        if (rawSum[`FP_MAN_W+4])
        begin
            norm    = {rawSum[`FP_MAN_W+4:2], rawSum[1] | rawSum[0]};
            normExp = {1'b0, aligned.exponentOut} + 9'd1;
        end
        else
        begin
            norm    = rawSum[`FP_MAN_W+3:0] << leftShift;
            normExp = {1'b0, aligned.exponentOut} - {4'b0000, leftShift};
        end
        expField = norm[`FP_MAN_W+3] ? normExp : 9'd0;

        // Incrementing the packed word carries into the exponent
        roundUp = norm[2] & (norm[1] | norm[0] | norm[3]);
        rounded = {expField, norm[`FP_MAN_W+2:3]} + (`FP_MAN_W+9)'(roundUp);

        sumFlags.invalid  = 1'b0;
        sumFlags.overflow = 1'b0;
        sumFlags.inexact  = norm[2] | norm[1] | norm[0];
        if (rawSum == '0)
            sumWord = '0;   // Exact cancellation gives +0
        else if (rounded[`FP_MAN_W+8:`FP_MAN_W] >= 9'(`FP_EXP_MAX))
        begin
            sumWord           = {resultSign, 8'hFF, {`FP_MAN_W{1'b0}}};
            sumFlags.overflow = 1'b1;
            sumFlags.inexact  = 1'b1;
        end
        else
            sumWord = {resultSign, rounded[`FP_MAN_W+7:0]};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            outValid <= 1'b0;
            result   <= '0;
            flags    <= '0;
        end
        else
        begin
            outValid <= stageValid;
            if (stageValid)
            begin
                result <= aligned.bypass ? special.result : sumWord;
                flags  <= aligned.bypass ? special.flags : sumFlags;
            end
        end
    end

endmodule

//--- logic/fpAdderTop.sv
// Two-stage binary32 adder/subtractor top level
`timescale 1ns/10ps
`include "fpAdder_consts.svh"

module fpAdderTop (
    input  logic               clk,
    input  logic               rst,
    input  logic               inValid,
    input  fpAdderPkg::fpOp    op,
    input  fpAdderPkg::fpWord  operandA,
    input  fpAdderPkg::fpWord  operandB,
    output logic               outValid,
    output fpAdderPkg::fpWord  result,
    output fpAdderPkg::fpFlags flags
);

    logic                  stageValid;
    fpAdderPkg::fpUnpacked unpacked;
    fpAdderPkg::fpAligned  aligned;
    fpAdderPkg::fpSpecial  special;

    fpUnpack unpackStage (
        .clk        (clk),
        .rst        (rst),
        .inValid    (inValid),
        .op         (op),
        .operandA   (operandA),
        .operandB   (operandB),
        .stageValid (stageValid),
        .unpacked   (unpacked)
    );

    // Arithmetic and special paths run side by side
    fpAlign alignStage (
        .unpacked (unpacked),
        .aligned  (aligned)
    );

    fpSpecialCase specialStage (
        .unpacked (unpacked),
        .special  (special)
    );

    fpAddNormRound normRoundStage (
        .clk        (clk),
        .rst        (rst),
        .stageValid (stageValid),
        .aligned    (aligned),
        .special    (special),
        .outValid   (outValid),
        .result     (result),
        .flags      (flags)
    );

endmodule

//--- verification/fpAdderTb.sv
// Binary32 adder testbench with golden vectors, pipelined issue, result, flag and hold checks
`timescale 1ns/10ps

module fpAdderTb;

    typedef struct packed
    {
        fpAdderPkg::fpOp    op;
        fpAdderPkg::fpWord  a;
        fpAdderPkg::fpWord  b;
        fpAdderPkg::fpWord  expResult;
        fpAdderPkg::fpFlags expFlags;
    } goldenVector;

    // Expected output and the cycle its outValid is due
    typedef struct packed
    {
        fpAdderPkg::fpWord  result;
        fpAdderPkg::fpFlags flags;
        int                 dueCycle;
    } pendingEntry;

    localparam int MaxVectors  = 64;
    localparam int ResetCycles = 16;

    logic               clk;
    logic               rst;
    logic               inValid;
    fpAdderPkg::fpOp    op;
    fpAdderPkg::fpWord  operandA;
    fpAdderPkg::fpWord  operandB;
    logic               outValid;
    fpAdderPkg::fpWord  result;
    fpAdderPkg::fpFlags flags;

    goldenVector vectors [MaxVectors];
    pendingEntry pending [$];
    int          vecCount     = 0;
    int          checkedCount = 0;
    int          cycleCount   = 0;
    int          cycleLimit   = 1000;   // Replaced once the vectors are loaded

    fpAdderPkg::fpWord  heldResult = '0;   // Output expected while outValid is low
    fpAdderPkg::fpFlags heldFlags  = '0;

    fpAdderTop dut (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .op       (op),
        .operandA (operandA),
        .operandB (operandB),
        .outValid (outValid),
        .result   (result),
        .flags    (flags)
    );

    always #2 clk = ~clk;

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic checkResult(input fpAdderPkg::fpWord got,
                               input fpAdderPkg::fpWord expected);
        if (got !== expected)
            stopRun($sformatf("[FAIL] result got %h expected %h", got, expected));
    endtask

    task automatic checkFlags(input fpAdderPkg::fpFlags got,
                              input fpAdderPkg::fpFlags expected);
        if (got !== expected)
            stopRun($sformatf("[FAIL] flags got %h expected %h", got, expected));
    endtask

    task automatic loadVectors();
        int          fd;
        int          count;
        string       line;
        logic [3:0]  opField;
        logic [31:0] aField;
        logic [31:0] bField;
        logic [31:0] resField;
        logic [3:0]  flagField;
        fd = $fopen("verification/fpAdderGolden.txt", "r");
        if (fd == 0)
            stopRun("Could not open the golden vector file");
        else
        begin
            while (!$feof(fd) && vecCount < MaxVectors)
            begin
                count = $fgets(line, fd);
                if (count != 0)
                begin
                    // Comment lines scan no fields and are skipped
                    count = $sscanf(line, "%h %h %h %h %h",
                                    opField, aField, bField, resField, flagField);
                    if (count == 5)
                    begin
                        vectors[vecCount].op        = fpAdderPkg::fpOp'(opField[0]);
                        vectors[vecCount].a         = aField;
                        vectors[vecCount].b         = bField;
                        vectors[vecCount].expResult = resField;
                        vectors[vecCount].expFlags  = flagField[2:0];
                        vecCount++;
                    end
                end
            end
            $fclose(fd);
            if (vecCount == 0)
                stopRun("The golden vector file holds no vectors");
        end
    endtask

    task automatic applyVector(input goldenVector v);
        pendingEntry entry;
        inValid        = 1'b1;
        op             = v.op;
        operandA       = v.a;
        operandB       = v.b;
        entry.result   = v.expResult;
        entry.flags    = v.expFlags;
        entry.dueCycle = cycleCount + 2;   // Sampled at the next edge and registered one edge later
        pending.push_back(entry);
        @(posedge clk);
        #1;
    endtask

    task automatic idleCycles(input int n);
        inValid = 1'b0;
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
            stopRun($sformatf("Timeout, the run did not finish within %0d cycles", cycleLimit));
    end

    // Outputs are read half a cycle after the edge that registered them
    always @(negedge clk)
    begin
        if (outValid)
        begin
            if (pending.size() == 0)
                stopRun("outValid was high with no operation in flight");
            else if (cycleCount != pending[0].dueCycle)
                stopRun($sformatf("Result arrived in cycle %0d instead of cycle %0d",
                                  cycleCount, pending[0].dueCycle));
            else
            begin
                checkResult(result, pending[0].result);
                checkFlags(flags, pending[0].flags);
                heldResult = pending[0].result;
                heldFlags  = pending[0].flags;
                void'(pending.pop_front());
                checkedCount++;
            end
        end
        else if (pending.size() != 0 && cycleCount >= pending[0].dueCycle)
            stopRun("An issued operation never raised outValid");
        else if (rst === 1'b0)
        begin
            // The last result holds until the next outValid
            checkResult(result, heldResult);
            checkFlags(flags, heldFlags);
        end
    end

    initial
    begin
        clk      = 1'b0;
        rst      = 1'b1;
        inValid  = 1'b0;
        op       = fpAdderPkg::OP_ADD;
        operandA = '0;
        operandB = '0;
        loadVectors();
        cycleLimit = ResetCycles + vecCount + 20;

        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
        checkResult(result, '0);
        checkFlags(flags, '0);

        // Two back-to-back bursts with a short gap
        for (int i = 0; i < vecCount; i++)
        begin
            if (i == vecCount / 2)
                idleCycles(3);
            applyVector(vectors[i]);
        end
        inValid = 1'b0;

        while (checkedCount < vecCount)
            @(posedge clk);
        repeat (2) @(negedge clk);   // Monitor flags any stray outValid here
        $display("Regression passed");
        $finish;
    end

endmodule

//--- fpAdder.f
+incdir+logic
logic/fpAdderPkg.sv
logic/fpUnpack.sv
logic/fpAlign.sv
logic/fpSpecialCase.sv
logic/fpAddNormRound.sv
logic/fpAdderTop.sv
verification/fpAdderTb.sv

//--- run.sh
#!/bin/sh
# Build the binary32 adder testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps --top-module fpAdderTb -f fpAdder.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/VfpAdderTb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
fi
exit "$status"

//--- verification/fpAdderGolden.txt
// op a b result flags, all hex; op 1 is subtract, flags bits are invalid overflow inexact
0 3FC00000 3FC00000 40400000 0
0 3F800000 3E800000 3FA00000 0
1 3F800000 40000000 BF800000 0
0 C0A00000 40400000 C0000000 0
1 3F800001 3F800000 34000000 0
1 C0490FDB C0490FDB 00000000 0
0 3F800000 30800000 3F800000 1
0 3F800000 33800000 3F800000 1
0 3F800001 33800000 3F800002 1
0 3F800000 33800001 3F800001 1
0 3FFFFFFF 33800000 40000000 1
0 7F800001 3F800000 7FC00000 0
0 7F800000 FF800000 7FC00000 4
0 3F800000 FF800000 FF800000 0
0 00000000 40490FDB 40490FDB 0
0 80000000 80000000 80000000 0
0 7F7FFFFF 7F7FFFFF 7F800000 3
0 00000001 00000002 00000003 0
0 00400000 00400000 00800000 0
